// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the convolution engine testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cnn_tb \
  -Mdir obj_dir -o cnn_sim -f sources.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cnn_sim +verilator+error+limit+1000 > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "** FAIL **" "$sim_log"; then
  exit 1
fi
exit 0

// File: source/cnn_fsm.sv
// Convolution sequencer ordering weight load, row reads, MAC, activation and write-back
`timescale 1ns/1ns

module cnn_fsm
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic       wgt_valid,
  input  logic       bias_valid,
  input  logic       pic_valid,
  input  logic       wr_ack,
  input  logic       row_last,   // Fourth kernel line
  input  logic       win_last,   // Last window of picture
  input  logic       word_full,  // This result closes the word
  output logic       busy,
  output logic       done,
  output logic [1:0] load_en,    // Bit 0 weights, bit 1 bias
  output logic       row_req,
  output logic       mac_en,
  output logic       act_en,
  output logic       write_en,
  output logic       clear
);

  fsm_state_t state, state_nx;
  logic       wgt_got;   // Weights arrived this run
  logic       bias_got;
  logic       last_q;    // Pending word holds last window
  logic       done_q;

  // ==========================================================================
  // Next state
  // ==========================================================================
  always_comb
  begin
    state_nx = state;
    unique case (state)
      idle:  if (go) state_nx = load;
      load:  if ((wgt_got || wgt_valid) && (bias_got || bias_valid)) state_nx = read;
      read:  if (pic_valid) state_nx = mac;
      mac:   state_nx = row_last ? act : read;
      act:   state_nx = (word_full || win_last) ? write : read;
      write:
      begin
        if (wr_ack)
          state_nx = last_q ? idle : read;
      end
      default: state_nx = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      wgt_got  <= 1'b0;
      bias_got <= 1'b0;
      last_q   <= 1'b0;
      done_q   <= 1'b0;
    end
    else
    begin
      state  <= state_nx;
      done_q <= (state == write) && wr_ack && last_q;  // Pulse after final ack
      if (clear)
      begin
        wgt_got  <= 1'b0;  // Fresh load each run
        bias_got <= 1'b0;
        last_q   <= 1'b0;
      end
      else
      begin
        if (state == load && wgt_valid)
          wgt_got <= 1'b1;
        if (state == load && bias_valid)
          bias_got <= 1'b1;
        if (act_en)
          last_q <= win_last;  // Window counter moves on this edge
      end
    end
  end

  // Step enables, all from state
  assign clear      = (state == idle) && go;
  assign load_en[0] = (state == load) && !wgt_got;   // Drops cycle after valid
  assign load_en[1] = (state == load) && !bias_got;
  assign row_req    = (state == read);
  assign mac_en     = (state == mac);
  assign act_en     = (state == act);
  assign write_en   = (state == write);
  assign busy       = (state != idle);
  assign done       = done_q;

endmodule

// File: source/cnn_pkg.sv
// Convolution engine package with memory port structs, data types and FSM states
package cnn_pkg;

  // ==========================================================================
  // Sizes
  // ==========================================================================
  localparam int addr_w = 19;  // Memory byte address
  localparam int k_dim  = 4;   // Kernel side, fixed 4x4

  // ==========================================================================
  // Memory port structs
  // ==========================================================================
  typedef struct packed {
    logic              req;         // Held until valid seen
    logic [addr_w-1:0] addr;
    logic [4:0]        size_bytes;  // Up to 16 bytes
  } rd_req_t;

  typedef struct packed {
    logic         valid;  // One cycle per request
    logic [127:0] data;   // Byte 0 in low lane
  } rd_rsp_t;

  typedef struct packed {
    logic              req;  // Held until wr_ack
    logic [addr_w-1:0] addr;
    logic [2:0]        size_bytes;  // 1..4 valid bytes
    logic [31:0]       data;
  } wr_req_t;

  // ==========================================================================
  // Datapath types
  // ==========================================================================
  typedef logic [k_dim-1:0][7:0] pix_row_t;         // Unsigned picture bytes
  typedef logic signed [k_dim-1:0][7:0] wgt_row_t;  // Signed weight bytes
  typedef logic signed [31:0] acc_t;

  // Sequencer states
  typedef enum logic [2:0] {
    idle,
    load,   // Weights and bias fetch
    read,   // One picture row
    mac,
    act,    // Saturate and pack
    write
  } fsm_state_t;

endpackage

// File: source/cnn_top.sv
// Convolution engine top joining sequencer, window counter, MAC and packer to memory ports
`timescale 1ns/1ns

module cnn_top
  import cnn_pkg::*;
#(
  parameter int pic_rows = 8,
  parameter int pic_cols = 8
)
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       go,
  output logic                       busy,
  output logic                       done,
  // Base addresses
  input  logic [cnn_pkg::addr_w-1:0] addr_x,  // Picture
  input  logic [cnn_pkg::addr_w-1:0] addr_w,  // Weights
  input  logic [cnn_pkg::addr_w-1:0] addr_b,  // Bias
  input  logic [cnn_pkg::addr_w-1:0] addr_z,  // Results
  output rd_req_t                    pic_rd,
  input  rd_rsp_t                    pic_rsp,
  output rd_req_t                    wgt_rd,
  input  rd_rsp_t                    wgt_rsp,
  output rd_req_t                    bias_rd,
  input  rd_rsp_t                    bias_rsp,
  output wr_req_t                    wr,
  input  logic                       wr_ack
);

  logic [1:0]                 load_en;
  logic                       row_req;
  logic                       mac_en;
  logic                       act_en;
  logic                       write_en;
  logic                       clear;
  logic                       row_last;
  logic                       win_last;
  logic                       word_full;
  logic [1:0]                 line;
  logic [cnn_pkg::addr_w-1:0] pic_addr;
  acc_t                       sum;

  // ==========================================================================
  // Read requests
  // ==========================================================================
  assign wgt_rd  = '{req: load_en[0], addr: addr_w, size_bytes: 5'd16};  // Whole 4x4
  assign bias_rd = '{req: load_en[1], addr: addr_b, size_bytes: 5'd4};
  assign pic_rd  = '{req: row_req, addr: pic_addr, size_bytes: 5'd4};    // One kernel line

  cnn_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (go),
    .wgt_valid  (wgt_rsp.valid),
    .bias_valid (bias_rsp.valid),
    .pic_valid  (pic_rsp.valid),
    .wr_ack     (wr_ack),
    .row_last   (row_last),
    .win_last   (win_last),
    .word_full  (word_full),
    .busy       (busy),
    .done       (done),
    .load_en    (load_en),
    .row_req    (row_req),
    .mac_en     (mac_en),
    .act_en     (act_en),
    .write_en   (write_en),
    .clear      (clear)
  );

  window_counter #(
    .pic_rows (pic_rows),
    .pic_cols (pic_cols)
  ) u_win (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .addr_x   (addr_x),
    .mac_en   (mac_en),
    .act_en   (act_en),
    .pic_addr (pic_addr),
    .line     (line),
    .row_last (row_last),
    .win_last (win_last)
  );

  mac_unit u_mac (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .load_en  (load_en),
    .wgt_rsp  (wgt_rsp),
    .bias_rsp (bias_rsp),
    .pic_rsp  (pic_rsp),
    .mac_en   (mac_en),
    .line     (line),
    .sum      (sum)
  );

  result_packer u_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .addr_z    (addr_z),
    .act_en    (act_en),
    .write_en  (write_en),
    .wr_ack    (wr_ack),
    .sum       (sum),
    .wr        (wr),
    .word_full (word_full)
  );

endmodule

// File: source/mac_unit.sv
// Weight and bias store with a 4-lane dot product feeding the window accumulator
`timescale 1ns/1ns

module mac_unit
  import cnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clear,
  input  logic [1:0] load_en,   // Bit 0 weights, bit 1 bias
  input  rd_rsp_t    wgt_rsp,
  input  rd_rsp_t    bias_rsp,
  input  rd_rsp_t    pic_rsp,
  input  logic       mac_en,
  input  logic [1:0] line,
  output acc_t       sum
);

  wgt_row_t w_mem [k_dim];  // One row per kernel line
  wgt_row_t w_sel;
  acc_t     bias_q;
  pix_row_t row_q;          // Latest picture row
  acc_t     dot;
  acc_t     acc;

  // ==========================================================================
  // Operand capture
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (load_en[0] && wgt_rsp.valid)
    begin
      for (int r = 0; r < k_dim; r++)
        w_mem[r] <= wgt_rsp.data[32*r +: 32];  // Row r at bytes 4r..4r+3
    end
    if (load_en[1] && bias_rsp.valid)
      bias_q <= bias_rsp.data[31:0];
    if (pic_rsp.valid)
      row_q <= pic_rsp.data[31:0];
  end

  assign w_sel = w_mem[line];

  // Signed weight times unsigned pixel, pixel widened with a zero sign bit
  always_comb
  begin
    dot = '0;
    for (int i = 0; i < k_dim; i++)
      dot = dot + acc_t'($signed(w_sel[i])) * acc_t'($signed({1'b0, row_q[i]}));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      acc <= '0;
    else if (clear)
      acc <= '0;
    else if (mac_en)
      acc <= ((line == 2'd0) ? bias_q : acc) + dot;  // Bias seeds each window
  end

  assign sum = acc;  // Complete one cycle after line 3

endmodule

// File: source/result_packer.sv
// Saturating ReLU with byte packing into write words and write address tracking
`timescale 1ns/1ns

module result_packer
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic [addr_w-1:0] addr_z,    // Result base
  input  logic              act_en,
  input  logic              write_en,
  input  logic              wr_ack,
  input  acc_t              sum,
  output wr_req_t           wr,
  output logic              word_full
);

  logic [2:0]        fill;     // Lanes in use, 0..4
  logic [addr_w-1:0] addr_q;
  pix_row_t          word_q;
  logic [7:0]        act_byte;
  logic              acked;

  assign acked = write_en && wr_ack;

  // Clamp to 0..255
  always_comb
  begin
    if (sum < 0)
      act_byte = 8'h00;
    else if (sum > acc_t'(255))
      act_byte = 8'hff;
    else
      act_byte = sum[7:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      fill <= '0;
    else if (clear || acked)
      fill <= '0;
    else if (act_en)
      fill <= fill + 3'd1;
  end

  always_ff @(posedge clk)
  begin
    if (clear)
    begin
      addr_q <= addr_z;
      word_q <= '0;
    end
    else if (acked)
    begin
      addr_q <= addr_q + addr_w'(4);  // Next word
      word_q <= '0;
    end
    else if (act_en)
      word_q[fill[1:0]] <= act_byte;  // First result in byte 0
  end

  // Lane 3 is next, so the current activation completes the word
  assign word_full = (fill == 3'd3);

  assign wr = '{req: write_en, addr: addr_q, size_bytes: fill, data: word_q};

endmodule

// File: source/window_counter.sv
// Window and kernel line counters generating picture row read addresses
`timescale 1ns/1ns

module window_counter
  import cnn_pkg::*;
#(
  parameter int pic_rows = 8,
  parameter int pic_cols = 8
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic [addr_w-1:0] addr_x,    // Picture base
  input  logic              mac_en,    // Next kernel line
  input  logic              act_en,    // Next window
  output logic [addr_w-1:0] pic_addr,
  output logic [1:0]        line,      // Kernel line, selects weight row
  output logic              row_last,
  output logic              win_last
);

  localparam int col_w   = $clog2(pic_cols);
  localparam int row_w   = $clog2(pic_rows);
  localparam int col_max = pic_cols - k_dim;  // Last window column
  localparam int row_max = pic_rows - k_dim;

  logic [col_w-1:0]  win_col;
  logic [row_w-1:0]  win_row;
  logic [addr_w-1:0] base_q;
  logic [addr_w-1:0] row_idx;
  logic              col_end;

  assign col_end = (win_col == col_w'(col_max));

  // Base taken at start of run
  always_ff @(posedge clk)
  begin
    if (clear)
      base_q <= addr_x;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      line    <= '0;
      win_col <= '0;
      win_row <= '0;
    end
    else if (clear)
    begin
      line    <= '0;
      win_col <= '0;
      win_row <= '0;
    end
    else
    begin
      if (mac_en)
        line <= line + 2'd1;  // Wraps back to 0 after line 3
      if (act_en)
      begin
        if (col_end)
        begin
          win_col <= '0;
          win_row <= (win_row == row_w'(row_max)) ? '0 : win_row + 1'b1;
        end
        else
          win_col <= win_col + 1'b1;
      end
    end
  end

  // Stride 1, row address = base + (row + line) * cols + col
  assign row_idx  = addr_w'(win_row) + addr_w'(line);
  assign pic_addr = base_q + row_idx * addr_w'(pic_cols) + addr_w'(win_col);

  assign row_last = (line == 2'd3);
  assign win_last = col_end && (win_row == row_w'(row_max));

endmodule

// File: sources.f
source/cnn_pkg.sv
source/cnn_fsm.sv
source/window_counter.sv
source/mac_unit.sv
source/result_packer.sv
source/cnn_top.sv
verif/cnn_chk.sv
verif/cnn_tb.sv

// File: verif/cnn_chk.sv
// Bound checker for write hold rules, single open reads and the done pulse
`timescale 1ns/1ns

module cnn_chk
  import cnn_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    busy,
  input logic    done,
  input rd_req_t pic_rd,
  input rd_rsp_t pic_rsp,
  input rd_req_t wgt_rd,
  input rd_rsp_t wgt_rsp,
  input rd_req_t bias_rd,
  input rd_rsp_t bias_rsp,
  input wr_req_t wr,
  input logic    wr_ack
);

  int fail_cnt = 0;  // Failed assertion count

  // Request fields frozen until ack
  wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr.req && !wr_ack |=> wr.req && $stable(wr.addr) && $stable(wr.data)
      && $stable(wr.size_bytes))
    else
    begin
      fail_cnt++;
      $error("write request changed before wr_ack");
    end

  wr_release: assert property (@(posedge clk) disable iff (!rst_n)
    wr.req && wr_ack |=> !wr.req)
    else
    begin
      fail_cnt++;
      $error("write request did not fall after wr_ack");
    end

  // Req drops right after valid, so no second request overlaps
  rd_single: assert property (@(posedge clk) disable iff (!rst_n)
    !($past(pic_rsp.valid) && pic_rd.req) && !($past(wgt_rsp.valid) && wgt_rd.req)
      && !($past(bias_rsp.valid) && bias_rd.req))
    else
    begin
      fail_cnt++;
      $error("read request stayed open after its valid");
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> !busy && $past(busy) && !$past(done))
    else
    begin
      fail_cnt++;
      $error("done is not a single pulse with busy falling");
    end

endmodule

bind cnn_top cnn_chk u_chk (.*);

// File: verif/cnn_tb.sv
// Convolution engine testbench with random latency memory model and reference results
`timescale 1ns/1ns

module cnn_tb
  import cnn_pkg::*;
();

  localparam int pic_rows  = 8;
  localparam int pic_cols  = 8;
  localparam int win_cols  = pic_cols - k_dim + 1;                 // Windows per row
  localparam int n_win     = (pic_rows - k_dim + 1) * win_cols;    // 25 results
  localparam int n_words   = (n_win + 3) / 4;
  localparam int last_size = n_win - 4 * (n_words - 1);           // Bytes in final word
  localparam int mem_size  = 1024;
  localparam logic [addr_w-1:0] base_x = 19'h00100;
  localparam logic [addr_w-1:0] base_w = 19'h00040;
  localparam logic [addr_w-1:0] base_b = 19'h00060;
  localparam logic [addr_w-1:0] base_z = 19'h00200;
  // Worst case per run: load, 4 lines of read plus mac per window, act, slow acks
  localparam int run_cyc    = 8 + n_win * (k_dim * 5 + 1) + n_words * 4;
  localparam int timeout_ns = 2 * 2 * run_cyc * 10 + 100;

  logic        clk;
  logic        rst_n;
  logic        go;
  logic        busy;
  logic        done;
  rd_req_t     pic_rd, wgt_rd, bias_rd;
  rd_rsp_t     pic_rsp, wgt_rsp, bias_rsp;
  wr_req_t     wr;
  logic        wr_ack;
  logic [7:0]  mem [mem_size];       // Byte memory behind all ports
  logic [31:0] exp_word [n_words];   // Reference packed results
  integer      seed;
  int          errors;
  int          wr_idx;               // Word index within current run
  string       test_name;

  cnn_top #(
    .pic_rows (pic_rows),
    .pic_cols (pic_cols)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .busy     (busy),
    .done     (done),
    .addr_x   (base_x),
    .addr_w   (base_w),
    .addr_b   (base_b),
    .addr_z   (base_z),
    .pic_rd   (pic_rd),
    .pic_rsp  (pic_rsp),
    .wgt_rd   (wgt_rd),
    .wgt_rsp  (wgt_rsp),
    .bias_rd  (bias_rd),
    .bias_rsp (bias_rsp),
    .wr       (wr),
    .wr_ack   (wr_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // Memory model
  // ==========================================================================
  function automatic logic [127:0] fetch16(input logic [addr_w-1:0] a);
    logic [127:0] d;
    d = '0;
    for (int k = 0; k < 16; k++)
      d[8*k +: 8] = mem[int'(a) + k];  // Byte 0 in low lane
    return d;
  endfunction

  function automatic rd_req_t port_req(input int port);
    case (port)
      0:       return pic_rd;
      1:       return wgt_rd;
      default: return bias_rd;
    endcase
  endfunction

  // Weights come as one 4x4 block, picture rows and bias as one word
  function automatic logic [4:0] read_size(input int port);
    return (port == 1) ? 5'd16 : 5'd4;
  endfunction

  task automatic put_rsp(input int port, input rd_rsp_t rsp);
    case (port)
      0:       pic_rsp  = rsp;
      1:       wgt_rsp  = rsp;
      default: bias_rsp = rsp;
    endcase
  endtask

  function automatic int rand_lat();
    return 1 + int'($unsigned($random(seed)) % 4);  // 1..4 cycles
  endfunction

  task automatic serve_read(input int port);
    rd_req_t rq;
    int      lat;
    forever
    begin
      @(posedge clk);
      #1;
      rq = port_req(port);
      if (rq.req)
      begin
        assert (rq.size_bytes == read_size(port))
        else
        begin
          errors++;
          $display("[ERROR] %s port %0d read size: expected %0d, actual %0d",
                   test_name, port, read_size(port), rq.size_bytes);
        end
        lat = rand_lat();
        repeat (lat - 1)
        begin
          @(posedge clk);
          #1;
        end
        put_rsp(port, rd_rsp_t'{valid: 1'b1, data: fetch16(rq.addr)});  // Single cycle valid
        @(posedge clk);
        #1;
        put_rsp(port, rd_rsp_t'{valid: 1'b0, data: '0});
      end
    end
  endtask

  // Compares the held write against the reference word for its index
  task automatic check_write();
    logic [addr_w-1:0] exp_addr;
    logic [2:0]        exp_size;
    exp_addr = base_z + addr_w'(4 * wr_idx);
    exp_size = (wr_idx == n_words - 1) ? 3'(last_size) : 3'd4;
    if (wr_idx >= n_words)
    begin
      errors++;
      $display("%s: engine wrote more than %0d words", test_name, n_words);
    end
    else
    begin
      assert (wr.data == exp_word[wr_idx])
      else
      begin
        errors++;
        $display("[ERROR] %s word %0d data: expected %h, actual %h",
                 test_name, wr_idx, exp_word[wr_idx], wr.data);
      end
      assert (wr.size_bytes == exp_size)
      else
      begin
        errors++;
        $display("[ERROR] %s word %0d size: expected %0d, actual %0d",
                 test_name, wr_idx, exp_size, wr.size_bytes);
      end
      assert (wr.addr == exp_addr)
      else
      begin
        errors++;
        $display("[ERROR] %s word %0d addr: expected %h, actual %h",
                 test_name, wr_idx, exp_addr, wr.addr);
      end
    end
    wr_idx++;
  endtask

  task automatic serve_write();
    int lat;
    forever
    begin
      @(posedge clk);
      #1;
      if (wr.req)
      begin
        lat = rand_lat();  // Ack delay, request must hold
        repeat (lat - 1)
        begin
          @(posedge clk);
          #1;
        end
        check_write();
        wr_ack = 1'b1;
        @(posedge clk);
        #1;
        wr_ack = 1'b0;
      end
    end
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================
  task automatic compute_expected(input int bias);
    int         s;
    int         k;
    logic [7:0] b;
    for (int j = 0; j < n_words; j++)
      exp_word[j] = '0;
    for (int r = 0; r <= pic_rows - k_dim; r++)
    begin
      for (int c = 0; c < win_cols; c++)
      begin
        s = bias;
        for (int l = 0; l < k_dim; l++)
          for (int i = 0; i < k_dim; i++)
            s += int'($signed(mem[base_w + 4*l + i]))
                 * int'(mem[base_x + (r + l) * pic_cols + c + i]);
        b = (s < 0) ? 8'h00 : (s > 255) ? 8'hff : s[7:0];  // ReLU with ceiling
        k = r * win_cols + c;
        exp_word[k / 4][8 * (k % 4) +: 8] = b;
      end
    end
  endtask

  // New small signed weights, -2..2
  task automatic load_weights();
    for (int i = 0; i < k_dim * k_dim; i++)
      mem[base_w + i] = 8'($random(seed) % 3);
  endtask

  task automatic run_engine(input string name, input int bias);
    test_name = name;
    load_weights();
    for (int k = 0; k < 4; k++)
      mem[base_b + k] = bias[8*k +: 8];  // Little endian bias word
    compute_expected(bias);
    wr_idx = 0;
    go = 1'b1;
    @(posedge clk);
    #1;
    go = 1'b0;
    assert (busy)
    else
    begin
      errors++;
      $display("%s: busy did not rise after go", name);
    end
    while (!done)  // Until the done pulse
    begin
      @(posedge clk);
      #1;
    end
    assert (!busy && wr_idx == n_words)
    else
    begin
      errors++;
      $display("%s: done came with busy high or after %0d writes", name, wr_idx);
    end
    @(posedge clk);
    #1;
    assert (!done)
    else
    begin
      errors++;
      $display("%s: done stayed high for more than one cycle", name);
    end
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial
  begin
    int chk_fails;
    seed     = 32'ha650_4275;
    errors   = 0;
    rst_n    = 1'b0;
    go       = 1'b0;
    wr_ack   = 1'b0;
    pic_rsp  = '0;
    wgt_rsp  = '0;
    bias_rsp = '0;
    for (int a = 0; a < mem_size; a++)
      mem[a] = 8'($random(seed));
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!busy && !done && !pic_rd.req && !wgt_rd.req && !bias_rd.req && !wr.req)
    else
    begin
      errors++;
      $display("reset: busy, done or a request is not low after reset");
    end
    fork
      serve_read(0);
      serve_read(1);
      serve_read(2);
      serve_write();
    join_none
    run_engine("run1", 100);
    run_engine("run2", -100);  // Reload with new weights and bias
    chk_fails = UUT.u_chk.fail_cnt;
    $display("Checks finished: %0d testbench errors, %0d assertion errors", errors, chk_fails);
    if (errors == 0 && chk_fails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    #(timeout_ns);
    $display("Watchdog: engine did not finish both runs within %0d ns", timeout_ns);
    $display("** FAIL **");
    $finish;
  end

endmodule
